//--- test/wb_cases.txt
# kind p0:val pc seq waddr wdata wen p1:val pc seq waddr wdata wen (all hex)
# then issue_val issue_waddr rd_addr, expected ex_rdy rd_data busy
# Both pipes requesting, grants alternate from pipe 0
arb 1 00000100 01 01 11110001 1 1 00000200 02 02 22220002 1 0 00 00 1 00000000 00000000
arb 1 00000104 03 03 33330003 1 1 00000200 02 02 22220002 1 0 00 01 2 00000000 00000000
arb 1 00000104 03 03 33330003 1 1 00000204 04 04 44440004 1 0 00 01 1 11110001 00000000
arb 1 00000108 05 05 55550005 1 1 00000204 04 04 44440004 1 0 00 02 2 22220002 00000000
arb 1 00000108 05 05 55550005 1 0 00000000 00 00 00000000 0 0 00 03 1 33330003 00000000
arb 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 04 0 44440004 00000000
arb 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 05 0 55550005 00000000
# Writes to register 0 and a result without wen
zero 0 00000000 00 00 00000000 0 1 00000300 10 00 deadbeef 1 0 00 00 2 00000000 00000000
zero 1 00000110 11 06 66660006 0 0 00000000 00 00 00000000 0 0 00 00 1 00000000 00000000
zero 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 00 0 00000000 00000000
zero 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 06 0 00000000 00000000
# Scoreboard set, clear, set wins, register 0 never busy
sb 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 1 07 00 0 00000000 00000000
sb 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 1 08 00 0 00000000 00000080
sb 0 00000000 00 00 00000000 0 1 00000310 20 07 77770007 1 1 00 00 2 00000000 00000180
sb 1 00000120 21 08 88880008 1 0 00000000 00 00 00000000 0 1 08 07 1 00000000 00000100
sb 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 07 0 77770007 00000100
sb 0 00000000 00 00 00000000 0 1 00000320 22 08 99990008 1 0 00 08 2 88880008 00000100
sb 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 1 09 08 0 88880008 00000000
sb 1 00000130 23 09 0000aaaa 0 0 00000000 00 00 00000000 0 0 00 08 1 99990008 00000200
sb 1 00000134 25 0a 0000cccc 1 1 00000330 24 09 0000bbbb 1 0 00 09 2 00000000 00000200
# Register file read back one cycle after commit
rf 1 00000134 25 0a 0000cccc 1 0 00000000 00 00 00000000 0 0 00 09 1 00000000 00000000
rf 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 09 0 0000bbbb 00000000
rf 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 0a 0 0000cccc 00000000
rf 1 00000140 26 1f fffffff1 1 0 00000000 00 00 00000000 0 0 00 0a 1 0000cccc 00000000
rf 1 00000144 27 1e eeeeeee2 1 1 00000340 28 1d ddddddd3 1 0 00 1f 2 00000000 00000000
rf 1 00000144 27 1e eeeeeee2 1 0 00000000 00 00 00000000 0 0 00 1f 1 fffffff1 00000000
rf 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 1d 0 ddddddd3 00000000
rf 0 00000000 00 00 00000000 0 0 00000000 00 00 00000000 0 0 00 1e 0 eeeeeee2 00000000

//--- files.f
src/wb_pkg.sv
src/rr_arb.sv
src/writeback_unit.sv
src/reg_file.sv
src/wb_scoreboard.sv
src/wb_top.sv
test/tb_wb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the writeback stage testbench with Verilator and runs it.
# Exits with status 0 only when the simulation output reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_wb_top -o sim_wb_top
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_wb_top 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# The verdict comes from the printed result line
if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- test/tb_wb_top.sv
//------------------------------
// Self-checking testbench for the writeback stage top level.
// Replays cycles from test/wb_cases.txt, then runs a seeded random
// phase; every output is compared with a reference model.
//------------------------------

`default_nettype none
`timescale 1ns/100ps

module tb_wb_top;

  localparam int num_pipes     = 2;
  localparam int clk_half      = 50;
  localparam int reset_cycles  = 5;
  localparam int reset_timeout = 20;
  localparam int max_lines     = 200;
  localparam int random_cycles = 200;

  logic                             clk;
  logic                             rst;
  wb_pkg::wb_req_t                  ex_req [num_pipes-1:0];
  logic [num_pipes-1:0]             ex_rdy;
  logic                             issue_val;
  logic [wb_pkg::reg_addr_bits-1:0] issue_waddr;
  logic [wb_pkg::reg_addr_bits-1:0] rd_addr;
  logic [wb_pkg::data_bits-1:0]     rd_data;
  wb_pkg::complete_t                complete;
  wb_pkg::commit_t                  commit;
  logic [wb_pkg::num_regs-1:0]      busy;

  // Reference model state
  int                           model_ptr;
  wb_pkg::wb_req_t              model_prev;
  logic [wb_pkg::data_bits-1:0] model_regs [wb_pkg::num_regs];
  logic [wb_pkg::num_regs-1:0]  model_busy;

  // Expected results for the cycle under test
  logic                         exp_found;
  int                           exp_win;
  wb_pkg::wb_req_t              exp_sel;
  logic [num_pipes-1:0]         exp_rdy;
  wb_pkg::complete_t            exp_complete;
  wb_pkg::commit_t              exp_commit;
  logic [wb_pkg::data_bits-1:0] exp_rd_data;
  logic [wb_pkg::num_regs-1:0]  exp_busy;

  logic [31:0] lcg_state;
  string       cur_label;
  int          case_count;

  wb_top #(
    .num_pipes (num_pipes)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .ex_req      (ex_req),
    .ex_rdy      (ex_rdy),
    .issue_val   (issue_val),
    .issue_waddr (issue_waddr),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .complete    (complete),
    .commit      (commit),
    .busy        (busy)
  );

  initial clk = 1'b0;
  always #clk_half clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  //------------------------------
  // Error handling and compares
  //------------------------------

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_rdy(input logic [num_pipes-1:0] got, input logic [num_pipes-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch ex_rdy: got %h expected %h in %0s", got, exp, cur_label));
    end
  endtask

  task automatic check_complete(input wb_pkg::complete_t got, input wb_pkg::complete_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch complete: got %h expected %h in %0s", got, exp, cur_label));
    end
  endtask

  task automatic check_commit(input wb_pkg::commit_t got, input wb_pkg::commit_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch commit: got %h expected %h in %0s", got, exp, cur_label));
    end
  endtask

  task automatic check_data(input logic [wb_pkg::data_bits-1:0] got,
                            input logic [wb_pkg::data_bits-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch rd_data: got %h expected %h in %0s", got, exp, cur_label));
    end
  endtask

  task automatic check_busy(input logic [wb_pkg::num_regs-1:0] got,
                            input logic [wb_pkg::num_regs-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch busy: got %h expected %h in %0s", got, exp, cur_label));
    end
  endtask

  //------------------------------
  // Reference model
  //------------------------------

  // First valid pipe at or after the pointer wins
  task automatic predict_outputs();
    int idx;
    exp_found = 1'b0;
    exp_win   = 0;
    exp_sel   = '0;
    exp_rdy   = '0;
    for (int k = 0; k < num_pipes; k++) begin
      idx = (model_ptr + k) % num_pipes;
      if (!exp_found && ex_req[idx].val) begin
        exp_found    = 1'b1;
        exp_win      = idx;
        exp_sel      = ex_req[idx];
        exp_rdy[idx] = 1'b1;
      end
    end
    exp_complete.val     = exp_sel.val;
    exp_complete.seq_num = exp_sel.seq_num;
    exp_complete.waddr   = exp_sel.waddr;
    exp_complete.wdata   = exp_sel.wdata;
    exp_complete.wen     = exp_sel.wen && (exp_sel.waddr != '0);
    // Commit replays last cycle's pick
    exp_commit.val     = model_prev.val;
    exp_commit.pc      = model_prev.pc;
    exp_commit.seq_num = model_prev.seq_num;
    exp_commit.waddr   = model_prev.waddr;
    exp_commit.wdata   = model_prev.wdata;
    exp_commit.wen     = model_prev.wen && (model_prev.waddr != '0);
    exp_rd_data = (rd_addr == '0) ? '0 : model_regs[rd_addr];
    exp_busy    = model_busy;
  endtask

  task automatic check_outputs();
    check_rdy(ex_rdy, exp_rdy);
    check_complete(complete, exp_complete);
    check_commit(commit, exp_commit);
    check_data(rd_data, exp_rd_data);
    check_busy(busy, exp_busy);
  endtask

  // State change at the coming rising edge
  task automatic advance_model();
    if (exp_found) begin
      model_ptr = (exp_win + 1) % num_pipes;
    end
    if (exp_commit.val && exp_commit.wen) begin
      model_regs[exp_commit.waddr] = exp_commit.wdata;
    end
    if (exp_complete.val && exp_complete.wen) begin
      model_busy[exp_complete.waddr] = 1'b0;
    end
    // Issue wins over a same-cycle clear
    if (issue_val && issue_waddr != '0) begin
      model_busy[issue_waddr] = 1'b1;
    end
    model_prev = exp_sel;
  endtask

  //------------------------------
  // Stimulus
  //------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic wb_pkg::wb_req_t random_request();
    wb_pkg::wb_req_t r;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    r.val     = (a[31:30] != 2'b00);
    r.pc      = {b[31:16], c[31:16]};
    r.seq_num = a[23:16];
    r.waddr   = a[28:24];
    r.wdata   = {c[31:16], b[31:16]} ^ {a[31:16], 16'h5a5a};
    r.wen     = a[29] | a[27];
    return r;
  endfunction

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      cycles++;
      if (cycles > reset_timeout) begin
        fail_run("reset was not released within the expected number of cycles");
      end
    end
  endtask

  // Each data line drives and checks one cycle
  task automatic run_case_line(input string line);
    logic [63:0] kind;
    logic [31:0] col [18];
    int          n;
    if (line.len() > 1 && line.getc(0) != "#") begin
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", kind,
                  col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                  col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
                  col[17]);
      case_count++;
      cur_label = $sformatf("case %0d (%0s)", case_count, kind);
      if (n != 19) begin
        fail_run($sformatf("%0s has the wrong number of columns", cur_label));
      end
      @(negedge clk);
      for (int p = 0; p < num_pipes; p++) begin
        ex_req[p].val     = col[6*p][0];
        ex_req[p].pc      = col[6*p+1];
        ex_req[p].seq_num = col[6*p+2][wb_pkg::seq_num_bits-1:0];
        ex_req[p].waddr   = col[6*p+3][wb_pkg::reg_addr_bits-1:0];
        ex_req[p].wdata   = col[6*p+4];
        ex_req[p].wen     = col[6*p+5][0];
      end
      issue_val   = col[12][0];
      issue_waddr = col[13][wb_pkg::reg_addr_bits-1:0];
      rd_addr     = col[14][wb_pkg::reg_addr_bits-1:0];
      #(clk_half / 2);
      predict_outputs();
      if (exp_rdy !== col[15][num_pipes-1:0] || exp_rd_data !== col[16] ||
          exp_busy !== col[17]) begin
        fail_run($sformatf("expected values of %0s disagree with the reference model",
                           cur_label));
      end
      check_outputs();
      advance_model();
    end
  endtask

  task automatic run_random_phase();
    wb_pkg::wb_req_t      next_req [num_pipes];
    logic [num_pipes-1:0] pending;
    logic [31:0]          r;
    pending = '0;
    for (int cyc = 0; cyc < random_cycles; cyc++) begin
      for (int p = 0; p < num_pipes; p++) begin
        if (!pending[p]) begin
          next_req[p] = random_request();
        end
      end
      r = next_rand();
      cur_label = $sformatf("random cycle %0d", cyc);
      @(negedge clk);
      for (int p = 0; p < num_pipes; p++) begin
        ex_req[p] = next_req[p];
      end
      issue_val   = r[31];
      issue_waddr = r[28:24];
      rd_addr     = r[20:16];
      #(clk_half / 2);
      predict_outputs();
      check_outputs();
      // A pipe that lost arbitration keeps its request
      for (int p = 0; p < num_pipes; p++) begin
        pending[p] = next_req[p].val && !exp_rdy[p];
      end
      advance_model();
    end
  endtask

  //------------------------------
  // Main sequence
  //------------------------------

  initial begin
    int    fd;
    int    rc;
    int    line_count;
    logic  done;
    string line;
    lcg_state   = 32'd80;
    issue_val   = 1'b0;
    issue_waddr = '0;
    rd_addr     = '0;
    for (int p = 0; p < num_pipes; p++) begin
      ex_req[p] = '0;
    end
    model_ptr  = 0;
    model_prev = '0;
    model_busy = '0;
    for (int r = 0; r < wb_pkg::num_regs; r++) begin
      model_regs[r] = '0;
    end
    case_count = 0;
    cur_label  = "reset";
    wait_reset_release();

    fd = $fopen("test/wb_cases.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the case file test/wb_cases.txt");
    end else begin
      line_count = 0;
      done       = 1'b0;
      while (!done) begin
        if (line_count >= max_lines) begin
          fail_run("case file did not end within the line limit");
        end
        rc = $fgets(line, fd);
        if (rc == 0) begin
          done = 1'b1;
        end else begin
          line_count++;
          run_case_line(line);
        end
      end
      $fclose(fd);
    end

    run_random_phase();

    if (case_count == 0) begin
      fail_run("no cases were found in the case file");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src/wb_top.sv
//----------------------------
// Writeback stage top level.
// Joins the writeback unit, register file and scoreboard;
// num_pipes sets how many execute pipes feed it.
//----------------------------

`default_nettype none
`timescale 1ns/100ps

module wb_top #(
  parameter int num_pipes = 2
) (
  input  wire logic                             clk,
  input  wire logic                             rst,

  // Execute pipes
  input  wb_pkg::wb_req_t                       ex_req [num_pipes-1:0],
  output logic      [num_pipes-1:0]             ex_rdy,

  // Issue strobe toward the scoreboard
  input  wire logic                             issue_val,
  input  wire logic [wb_pkg::reg_addr_bits-1:0] issue_waddr,

  // Register file read port
  input  wire logic [wb_pkg::reg_addr_bits-1:0] rd_addr,
  output logic      [wb_pkg::data_bits-1:0]     rd_data,

  // Notifications and status
  output wb_pkg::complete_t                     complete,
  output wb_pkg::commit_t                       commit,
  output logic      [wb_pkg::num_regs-1:0]      busy
);

  //----------------------------
  // Writeback
  //----------------------------

  writeback_unit #(
    .num_pipes (num_pipes)
  ) wb_unit (
    .clk      (clk),
    .rst      (rst),
    .ex_req   (ex_req),
    .ex_rdy   (ex_rdy),
    .complete (complete),
    .commit   (commit)
  );

  //----------------------------
  // Architectural state
  //----------------------------

  reg_file rf (
    .clk     (clk),
    .rst     (rst),
    .commit  (commit),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Busy tracking driven by completion
  wb_scoreboard sb (
    .clk         (clk),
    .rst         (rst),
    .issue_val   (issue_val),
    .issue_waddr (issue_waddr),
    .complete    (complete),
    .busy        (busy)
  );

endmodule

`default_nettype wire

//--- src/wb_scoreboard.sv
//----------------------------
// Register scoreboard of outstanding results.
// Issue marks a destination busy and a writing completion frees it.
//----------------------------

`default_nettype none
`timescale 1ns/100ps

module wb_scoreboard (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             issue_val,
  input  wire logic [wb_pkg::reg_addr_bits-1:0] issue_waddr,
  input  wb_pkg::complete_t                     complete,
  output logic      [wb_pkg::num_regs-1:0]      busy
);

  logic [wb_pkg::num_regs-1:0] set_vec;
  logic [wb_pkg::num_regs-1:0] clr_vec;

  //----------------------------
  // Decode
  //----------------------------

  always_comb begin
    set_vec = '0;
    if (issue_val) begin
      set_vec[issue_waddr] = 1'b1;
    end
    // Register 0 is never outstanding
    set_vec[0] = 1'b0;
  end

  // Completion wen is already low for register 0
  always_comb begin
    clr_vec = '0;
    if (complete.val && complete.wen) begin
      clr_vec[complete.waddr] = 1'b1;
    end
  end

  //----------------------------
  // Busy bits
  //----------------------------

  // Set applied after clear so a same-cycle issue keeps the bit
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~clr_vec) | set_vec;
    end
  end

endmodule

`default_nettype wire

//--- src/reg_file.sv
//----------------------------
// Architectural register file written by commit.
// One combinational read port; register 0 reads as zero.
//----------------------------

`default_nettype none
`timescale 1ns/100ps

module reg_file (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wb_pkg::commit_t                       commit,
  input  wire logic [wb_pkg::reg_addr_bits-1:0] rd_addr,
  output logic      [wb_pkg::data_bits-1:0]     rd_data
);

  // Register 0 has no storage
  logic [wb_pkg::data_bits-1:0] regs [1:wb_pkg::num_regs-1];
  logic                         wr_en;

  assign wr_en = commit.val && commit.wen && (commit.waddr != '0);

  //----------------------------
  // Write port
  //----------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 1; r < wb_pkg::num_regs; r++) begin
        regs[r] <= '0;
      end
    end else if (wr_en) begin
      regs[commit.waddr] <= commit.wdata;
    end
  end

  //----------------------------
  // Read port
  //----------------------------

  always_comb begin
    if (rd_addr == '0) begin
      rd_data = '0;
    end else begin
      rd_data = regs[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- src/writeback_unit.sv
//----------------------------
// Writeback unit for several execute pipes.
// Picks one finished instruction per cycle, announces completion
// at once and commit one cycle later.
//----------------------------

`default_nettype none
`timescale 1ns/100ps

module writeback_unit #(
  parameter int num_pipes = 2
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wb_pkg::wb_req_t       ex_req [num_pipes-1:0],
  output logic [num_pipes-1:0]  ex_rdy,
  output wb_pkg::complete_t     complete,
  output wb_pkg::commit_t       commit
);

  localparam int req_bits = $bits(wb_pkg::wb_req_t);

  //----------------------------
  // Pipe selection
  //----------------------------

  logic [num_pipes-1:0] ex_val;
  logic [num_pipes-1:0] ex_gnt;
  wb_pkg::wb_req_t      masked [num_pipes-1:0];
  wb_pkg::wb_req_t      sel;

  genvar i;
  generate
    for (i = 0; i < num_pipes; i++) begin : g_pipe
      assign ex_val[i] = ex_req[i].val;
      // Zero every field of a pipe that lost arbitration
      assign masked[i] = ex_req[i] & {req_bits{ex_gnt[i]}};
    end
  endgenerate

  rr_arb #(
    .num_pipes (num_pipes)
  ) ex_arb (
    .clk (clk),
    .rst (rst),
    .req (ex_val),
    .gnt (ex_gnt)
  );

  // Grant is one-hot so OR-ing the masked requests picks the winner
  always_comb begin
    sel = '0;
    for (int p = 0; p < num_pipes; p++) begin
      sel = sel | masked[p];
    end
  end

  // No downstream stall, so a grant is the ready
  assign ex_rdy = ex_gnt;

  //----------------------------
  // Completion notice
  //----------------------------

  assign complete = '{
    val:     sel.val,
    seq_num: sel.seq_num,
    waddr:   sel.waddr,
    wdata:   sel.wdata,
    wen:     sel.wen && (sel.waddr != '0)
  };

  //----------------------------
  // Commit register
  //----------------------------

  wb_pkg::wb_req_t commit_q;

  // Control bits
  always_ff @(posedge clk) begin
    if (rst) begin
      commit_q.val <= 1'b0;
      commit_q.wen <= 1'b0;
    end else begin
      commit_q.val <= sel.val;
      commit_q.wen <= sel.wen;
    end
  end

  // Payload follows the selection every cycle
  always_ff @(posedge clk) begin
    commit_q.pc      <= sel.pc;
    commit_q.seq_num <= sel.seq_num;
    commit_q.waddr   <= sel.waddr;
    commit_q.wdata   <= sel.wdata;
  end

  assign commit = '{
    val:     commit_q.val,
    pc:      commit_q.pc,
    seq_num: commit_q.seq_num,
    waddr:   commit_q.waddr,
    wdata:   commit_q.wdata,
    wen:     commit_q.wen && (commit_q.waddr != '0)
  };

endmodule

`default_nettype wire

//--- src/rr_arb.sv
//----------------------------
// Round-robin arbiter with a rotating priority pointer.
// Grant is combinational; the pointer moves past each winner.
//----------------------------

`default_nettype none
`timescale 1ns/100ps

module rr_arb #(
  parameter int num_pipes = 2
) (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic [num_pipes-1:0] req,
  output logic      [num_pipes-1:0] gnt
);

  // At least one pointer bit even for a single requester
  localparam int ptr_bits = (num_pipes > 1) ? $clog2(num_pipes) : 1;

  logic [ptr_bits-1:0] ptr;
  logic [ptr_bits-1:0] win_idx;
  logic                found;

  //----------------------------
  // Grant search
  //----------------------------

  // Scan from the pointer upward and wrap around
  always_comb begin
    int idx;
    gnt     = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int k = 0; k < num_pipes; k++) begin
      idx = (int'(ptr) + k) % num_pipes;
      if (!found && req[idx]) begin
        found    = 1'b1;
        gnt[idx] = 1'b1;
        win_idx  = ptr_bits'(idx);
      end
    end
  end

  //----------------------------
  // Priority pointer
  //----------------------------

  // One past the winner so a busy pipe cannot starve the rest
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (found) begin
      if (int'(win_idx) == num_pipes - 1) begin
        ptr <= '0;
      end else begin
        ptr <= win_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/wb_pkg.sv
//----------------------------
// Shared widths and notification structs for the writeback stage.
// Modules refer to these through wb_pkg:: scoped names.
//----------------------------

`default_nettype none

package wb_pkg;

  // Datapath widths
  localparam int addr_bits     = 32;
  localparam int data_bits     = 32;
  localparam int seq_num_bits  = 8;
  localparam int reg_addr_bits = 5;
  localparam int num_regs      = 32;

  //----------------------------
  // Execute to writeback
  //----------------------------

  // One finished instruction from an execute pipe
  typedef struct packed {
    logic                     val;
    logic [addr_bits-1:0]     pc;
    logic [seq_num_bits-1:0]  seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } wb_req_t;

  //----------------------------
  // Notifications
  //----------------------------

  // Same-cycle completion without pc
  typedef struct packed {
    logic                     val;
    logic [seq_num_bits-1:0]  seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } complete_t;

  // Registered commit toward the register file
  typedef struct packed {
    logic                     val;
    logic [addr_bits-1:0]     pc;
    logic [seq_num_bits-1:0]  seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } commit_t;

endpackage

`default_nettype wire
